//--- filelist.f
source/cache_pkg.sv
source/main_memory.sv
source/mem_arbiter.sv
source/icache.sv
source/dcache.sv
source/cache_top.sv
test/cache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module cache_tb -f filelist.f -o cache_sim

status=0
./obj_dir/cache_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"

//--- source/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int INDEX_W = 4;
    localparam int TAG_W = 10;

    // address fields: tag [15:6], index [5:2], byte offset [1:0]
    localparam int INDEX_LSB = 2;
    localparam int TAG_LSB = INDEX_LSB + INDEX_W;
    localparam int LINES = 2 ** INDEX_W;

    // core side request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              write;
    } cpu_req_t;

    // request towards main memory
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              write;
    } mem_req_t;

    // one direct-mapped entry
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } cache_line_t;

    function automatic logic [INDEX_W-1:0] addr_index(input logic [ADDR_W-1:0] addr);
        return addr[INDEX_LSB +: INDEX_W];
    endfunction

    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[TAG_LSB +: TAG_W];
    endfunction

endpackage

//--- source/cache_top.sv
module cache_top import cache_pkg::*; #(
    parameter int MEM_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ireq_valid,
    input  cpu_req_t          ireq,
    output logic              ireq_ready,
    output logic [DATA_W-1:0] irdata,
    input  logic              dreq_valid,
    input  cpu_req_t          dreq,
    output logic              dreq_ready,
    output logic [DATA_W-1:0] drdata
);

    logic              ic_mem_valid;
    mem_req_t          ic_mem_req;
    logic              ic_mem_ready;
    logic [DATA_W-1:0] ic_mem_rdata;
    logic              dc_mem_valid;
    mem_req_t          dc_mem_req;
    logic              dc_mem_ready;
    logic [DATA_W-1:0] dc_mem_rdata;
    logic              mem_valid;
    mem_req_t          mem_req;
    logic              mem_ready;
    logic [DATA_W-1:0] mem_rdata;

    icache icache_i (
        .clk(clk), .rst(rst),
        .req_valid(ireq_valid), .req(ireq), .req_ready(ireq_ready), .rdata(irdata),
        .mem_valid(ic_mem_valid), .mem_req(ic_mem_req),
        .mem_ready(ic_mem_ready), .mem_rdata(ic_mem_rdata)
    );

    dcache dcache_i (
        .clk(clk), .rst(rst),
        .req_valid(dreq_valid), .req(dreq), .req_ready(dreq_ready), .rdata(drdata),
        .mem_valid(dc_mem_valid), .mem_req(dc_mem_req),
        .mem_ready(dc_mem_ready), .mem_rdata(dc_mem_rdata)
    );

    mem_arbiter mem_arbiter_i (
        .clk(clk), .rst(rst),
        .i_valid(ic_mem_valid), .i_req(ic_mem_req),
        .i_ready(ic_mem_ready), .i_rdata(ic_mem_rdata),
        .d_valid(dc_mem_valid), .d_req(dc_mem_req),
        .d_ready(dc_mem_ready), .d_rdata(dc_mem_rdata),
        .mem_valid(mem_valid), .mem_req(mem_req),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    main_memory #(.MEM_LATENCY(MEM_LATENCY)) main_memory_i (
        .clk(clk), .rst(rst),
        .valid(mem_valid), .req(mem_req), .ready(mem_ready), .rdata(mem_rdata)
    );

endmodule

//--- source/dcache.sv
module dcache import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  cpu_req_t          req,
    output logic              req_ready,
    output logic [DATA_W-1:0] rdata,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ready,
    input  logic [DATA_W-1:0] mem_rdata
);

    typedef enum logic [1:0] {IDLE, COMPARE_TAG, WRITE_BACK, ALLOCATE} state_t;

    state_t             state;
    state_t             state_next;
    cache_line_t        lines [LINES];
    cpu_req_t           req_q;
    logic [INDEX_W-1:0] index;
    cache_line_t        line;
    logic               hit;

    assign index = addr_index(req_q.addr);
    assign line = lines[index];
    assign hit = line.valid && (line.tag == addr_tag(req_q.addr));

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (req_valid)
                    state_next = COMPARE_TAG;
            end
            COMPARE_TAG:
            begin
                if (hit)
                    state_next = IDLE;
                else if (line.valid && line.dirty)
                    state_next = WRITE_BACK;
                else
                    state_next = ALLOCATE;
            end
            WRITE_BACK:
            begin
                if (mem_ready)
                    state_next = ALLOCATE;
            end
            ALLOCATE:
            begin
                if (mem_ready)
                    state_next = COMPARE_TAG;
            end
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && req_valid)
            req_q <= req;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < LINES; i++)
                lines[i].valid <= 1'b0;
        end
        else if (state == COMPARE_TAG && hit && req_q.write)
        begin
            // store hit, merged in the ready cycle
            lines[index].data <= req_q.wdata;
            lines[index].dirty <= 1'b1;
        end
        else if (state == ALLOCATE && mem_ready)
        begin
            lines[index] <= '{valid: 1'b1, dirty: 1'b0, tag: addr_tag(req_q.addr),
                              data: mem_rdata};
        end
    end

    assign req_ready = (state == COMPARE_TAG) && hit;
    assign rdata = line.data;
    assign mem_valid = (state == WRITE_BACK) || (state == ALLOCATE);

    always_comb
    begin
        if (state == WRITE_BACK)
            mem_req = '{addr: {line.tag, index, 2'b00}, wdata: line.data, write: 1'b1};
        else
            mem_req = '{addr: {req_q.addr[ADDR_W-1:2], 2'b00}, wdata: '0, write: 1'b0};
    end

    // dirty miss must evict the old tag before refilling
    a_wb_req: assert property (@(posedge clk) disable iff (rst)
        state == COMPARE_TAG && !hit && line.valid && line.dirty
        |=> mem_valid && mem_req.write && addr_tag(mem_req.addr) == $past(line.tag));

    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_req));

endmodule

//--- source/icache.sv
module icache import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  cpu_req_t          req,
    output logic              req_ready,
    output logic [DATA_W-1:0] rdata,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ready,
    input  logic [DATA_W-1:0] mem_rdata
);

    typedef enum logic [1:0] {IDLE, COMPARE_TAG, ALLOCATE} state_t;

    state_t            state;
    state_t            state_next;
    cache_line_t       lines [LINES];
    logic [ADDR_W-1:0] addr_q;
    logic [INDEX_W-1:0] index;
    cache_line_t       line;
    logic              hit;

    assign index = addr_index(addr_q);
    assign line = lines[index];
    assign hit = line.valid && (line.tag == addr_tag(addr_q));

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (req_valid)
                    state_next = COMPARE_TAG;
            end
            COMPARE_TAG:
            begin
                state_next = hit ? IDLE : ALLOCATE;
            end
            ALLOCATE:
            begin
                if (mem_ready)
                    state_next = COMPARE_TAG;
            end
            default:
                state_next = IDLE;
        endcase
    end

    // address is held by the core, latched once in idle
    always_ff @(posedge clk)
    begin
        if (state == IDLE && req_valid)
            addr_q <= req.addr;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < LINES; i++)
                lines[i].valid <= 1'b0;
        end
        else if (state == ALLOCATE && mem_ready)
        begin
            lines[index] <= '{valid: 1'b1, dirty: 1'b0, tag: addr_tag(addr_q), data: mem_rdata};
        end
    end

    assign req_ready = (state == COMPARE_TAG) && hit;
    assign rdata = line.data;
    assign mem_valid = (state == ALLOCATE);
    assign mem_req = '{addr: {addr_q[ADDR_W-1:2], 2'b00}, wdata: '0, write: 1'b0};

    a_no_write: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !req.write);

    a_idle_no_mem: assert property (@(posedge clk) disable iff (rst)
        state == IDLE |-> !mem_valid);

endmodule

//--- source/main_memory.sv
module main_memory import cache_pkg::*; #(
    parameter int MEM_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid,
    input  mem_req_t          req,
    output logic              ready,
    output logic [DATA_W-1:0] rdata
);

    localparam int WORDS = 2 ** (ADDR_W - 2);
    localparam int CNT_W = $clog2(MEM_LATENCY) + 1;

    logic [DATA_W-1:0] mem [WORDS];
    logic              busy;
    logic [CNT_W-1:0]  count;
    logic [ADDR_W-3:0] word;

    assign word = req.addr[ADDR_W-1:2];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            count <= '0;
        end
        else if (!busy && valid)
        begin
            busy <= 1'b1;
            count <= CNT_W'(MEM_LATENCY - 1);
        end
        else if (ready)
            busy <= 1'b0;
        else if (busy)
            count <= count - 1'b1;
    end

    // reset image: C0DE in the upper half, byte address below
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < WORDS; i++)
                mem[i] <= {16'hC0DE, 16'(i << 2)};
        end
        else if (ready && req.write)
            mem[word] <= req.wdata;
    end

    assign ready = busy && (count == '0);
    assign rdata = mem[word];

endmodule

//--- source/mem_arbiter.sv
module mem_arbiter import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  mem_req_t          i_req,
    output logic              i_ready,
    output logic [DATA_W-1:0] i_rdata,
    input  logic              d_valid,
    input  mem_req_t          d_req,
    output logic              d_ready,
    output logic [DATA_W-1:0] d_rdata,
    output logic              mem_valid,
    output mem_req_t          mem_req,
    input  logic              mem_ready,
    input  logic [DATA_W-1:0] mem_rdata
);

    logic granted;
    logic grant_d;
    logic last_d;

    // grant held for a whole transaction and dropped for one cycle after
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            granted <= 1'b0;
            grant_d <= 1'b0;
            last_d <= 1'b0;
        end
        else if (granted)
        begin
            if (mem_ready)
            begin
                granted <= 1'b0;
                last_d <= grant_d;
            end
        end
        else if (i_valid || d_valid)
        begin
            granted <= 1'b1;
            // tie goes to whoever did not go last
            grant_d <= d_valid && (!i_valid || !last_d);
        end
    end

    assign mem_valid = granted && (grant_d ? d_valid : i_valid);
    assign mem_req = grant_d ? d_req : i_req;

    assign i_ready = granted && !grant_d && mem_ready;
    assign d_ready = granted && grant_d && mem_ready;
    assign i_rdata = (granted && !grant_d) ? mem_rdata : '0;
    assign d_rdata = (granted && grant_d) ? mem_rdata : '0;

    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        !(i_ready && d_ready));

endmodule

//--- test/cache_tb.sv
module cache_tb import cache_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;
    localparam int WORDS = 2 ** (ADDR_W - 2);

    logic              clk;
    logic              rst;
    logic              ireq_valid;
    cpu_req_t          ireq;
    logic              ireq_ready;
    logic [DATA_W-1:0] irdata;
    logic              dreq_valid;
    cpu_req_t          dreq;
    logic              dreq_ready;
    logic [DATA_W-1:0] drdata;

    // expected memory image, seen through the caches
    logic [DATA_W-1:0] shadow [WORDS];

    int    check_errors;
    int    timeouts;
    int    seed;
    string test_name;

    cache_top #(.MEM_LATENCY(3)) dut_i (
        .clk(clk), .rst(rst),
        .ireq_valid(ireq_valid), .ireq(ireq), .ireq_ready(ireq_ready), .irdata(irdata),
        .dreq_valid(dreq_valid), .dreq(dreq), .dreq_ready(dreq_ready), .drdata(drdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    a_ifetch_data: assert property (@(posedge clk) disable iff (rst)
        ireq_valid && ireq_ready |-> irdata == shadow[ireq.addr[ADDR_W-1:2]])
    else
    begin
        check_errors++;
        $display("[ERROR] %s: expected %h, actual %h", test_name,
                 shadow[$sampled(ireq.addr[ADDR_W-1:2])], $sampled(irdata));
    end

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        dreq_valid && dreq_ready && !dreq.write |-> drdata == shadow[dreq.addr[ADDR_W-1:2]])
    else
    begin
        check_errors++;
        $display("[ERROR] %s: expected %h, actual %h", test_name,
                 shadow[$sampled(dreq.addr[ADDR_W-1:2])], $sampled(drdata));
    end

    // ready only ever answers a pending request
    a_iready_valid: assert property (@(posedge clk) disable iff (rst)
        ireq_ready |-> ireq_valid)
    else
    begin
        check_errors++;
        $display("instruction port raised ready without a request");
    end

    a_dready_valid: assert property (@(posedge clk) disable iff (rst)
        dreq_ready |-> dreq_valid)
    else
    begin
        check_errors++;
        $display("data port raised ready without a request");
    end

    task automatic fetch(input logic [ADDR_W-1:0] addr, output int waits);
        int n;
        n = 0;
        @(posedge clk);
        ireq_valid <= 1'b1;
        ireq <= '{addr: addr, wdata: '0, write: 1'b0};
        @(negedge clk);
        while (!ireq_ready && n < TIMEOUT)
        begin
            n++;
            @(negedge clk);
        end
        if (!ireq_ready)
        begin
            timeouts++;
            $display("instruction port never answered a fetch of %h", addr);
        end
        @(posedge clk);
        ireq_valid <= 1'b0;
        waits = n;
    endtask

    task automatic access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                          input logic write);
        int   n;
        logic done;
        n = 0;
        @(posedge clk);
        dreq_valid <= 1'b1;
        dreq <= '{addr: addr, wdata: wdata, write: write};
        @(negedge clk);
        while (!dreq_ready && n < TIMEOUT)
        begin
            n++;
            @(negedge clk);
        end
        done = dreq_ready;
        if (!done)
        begin
            timeouts++;
            $display("data port never answered an access to %h", addr);
        end
        @(posedge clk);
        dreq_valid <= 1'b0;
        if (done && write)
            shadow[addr[ADDR_W-1:2]] = wdata;
    endtask

    initial
    begin
        int                waits;
        logic [DATA_W-1:0] r_i;
        logic [DATA_W-1:0] r_d;
        logic [DATA_W-1:0] wd;

        check_errors = 0;
        timeouts = 0;
        seed = 32'h2106c320;
        test_name = "reset";
        rst = 1'b1;
        ireq_valid = 1'b0;
        ireq = '0;
        dreq_valid = 1'b0;
        dreq = '0;
        for (int i = 0; i < WORDS; i++)
            shadow[i] = {16'hC0DE, 16'(i * 4)};

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        test_name = "ifetch_miss_then_hit";
        fetch(16'h8020, waits);
        fetch(16'h8020, waits);
        assert (waits == 1)
        else
        begin
            check_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", test_name, 1, waits);
        end

        test_name = "store_then_load";
        access(16'h0010, 32'h1234_5678, 1'b1);
        access(16'h0010, '0, 1'b0);

        // same index 0, tags 4 and 8
        test_name = "dirty_eviction";
        access(16'h0100, 32'hDEAD_BEEF, 1'b1);
        access(16'h0200, '0, 1'b0);
        access(16'h0100, '0, 1'b0);

        // instruction side stays in the upper half, never written by data
        test_name = "random_mix";
        for (int k = 0; k < 60; k++)
        begin
            r_i = $random(seed);
            r_d = $random(seed);
            wd = $random(seed);
            fork
                fetch({1'b1, 5'b0, r_i[9:2], 2'b00}, waits);
                access({1'b0, 5'b0, r_d[9:2], 2'b00}, wd, r_d[0]);
            join
        end

        test_name = "fetch_after_writeback";
        access(16'h0044, 32'h5A5A_0044, 1'b1);
        access(16'h0084, '0, 1'b0);
        fetch(16'h0044, waits);

        repeat (2) @(posedge clk);
        $display("checks failed: %0d, timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
